// ==== Bender.yml ====
package:
  name: multi_cycle_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rvPkg.sv
      - source/mainController.sv
      - source/stageRegisters.sv
      - source/registerFile.sv
      - source/alu.sv
      - source/immExtend.sv
      - source/multiCycleCore.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/coreTb.sv

// ==== filelist.f ====
+incdir+source
source/rvPkg.sv
source/mainController.sv
source/stageRegisters.sv
source/registerFile.sv
source/alu.sv
source/immExtend.sv
source/multiCycleCore.sv
tests/coreTb.sv

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvDefines.svh"

module alu (
        input  rvPkg::aluOp_t          aluOp,
        input  wire [2:0]              func3,
        input  wire                    func7bit5,
        input  wire [`XLEN-1:0]        a,
        input  wire [`XLEN-1:0]        b,
        output logic [`XLEN-1:0]       y,
        output logic                   zero,
        output logic                   neg
);
        import rvPkg::*;

        logic [`XLEN-1:0] sum;
        logic [`XLEN-1:0] diff;

        assign sum  = a + b;
        assign diff = a - b;

        // true sign of a - b, corrected for overflow.
        assign neg = diff[`XLEN-1] ^
                     ((a[`XLEN-1] ^ b[`XLEN-1]) & (a[`XLEN-1] ^ diff[`XLEN-1]));

        always_comb begin
                case (aluOp)
                        aluAdd: y = sum;
                        aluSub: y = diff;
                        default: begin
                                case (func3)
                                        3'b000:  y = func7bit5 ? diff : sum;
                                        3'b010:  y = {{(`XLEN-1){1'b0}}, neg};   // slt.
                                        3'b110:  y = a | b;
                                        3'b111:  y = a & b;
                                        default: y = sum;
                                endcase
                        end
                endcase
        end

        assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== source/immExtend.sv ====
`timescale 1ns/10ps
`default_nettype none

module immExtend (
        input  wire [31:7]         instr,
        input  rvPkg::immFmt_t     immFmt,
        output logic [31:0]        imm
);
        import rvPkg::*;

        always_comb begin
                case (immFmt)
                        immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                        immB: imm = {{19{instr[31]}}, instr[31], instr[7],
                                     instr[30:25], instr[11:8], 1'b0};
                        immU: imm = {instr[31:12], 12'b0};
                        immJ: imm = {{11{instr[31]}}, instr[31], instr[19:12],
                                     instr[20], instr[30:21], 1'b0};
                        default: imm = {{20{instr[31]}}, instr[31:20]};   // I format.
                endcase
        end

endmodule

`default_nettype wire

// ==== source/mainController.sv ====
`timescale 1ns/10ps
`default_nettype none

module mainController (
        input  wire                clk,
        input  wire                rstN,
        input  rvPkg::opcode_t     op,
        input  wire [2:0]          func3,
        input  wire                func7bit5,
        input  wire                zero,
        input  wire                neg,
        input  wire                memReady,
        output logic               memValid,
        output logic               memWrite,
        output logic               pcWrite,
        output logic               adrSrc,
        output logic               irWrite,
        output logic               regWrite,
        output rvPkg::aluOp_t      aluOp,
        output rvPkg::srcA_t       srcA,
        output rvPkg::srcB_t       srcB,
        output rvPkg::resultSrc_t  resultSrc,
        output rvPkg::immFmt_t     immFmt
);
        import rvPkg::*;

        ctrlState_t state;
        ctrlState_t nextState;
        logic       memXfer;
        logic       taken;

        assign memXfer = memValid && memReady;

        always_comb begin
                case (func3)
                        3'b000:  taken = zero;       // beq.
                        3'b001:  taken = !zero;      // bne.
                        3'b100:  taken = neg;        // blt.
                        3'b101:  taken = !neg;       // bge.
                        default: taken = 1'b0;
                endcase
        end

        // **************************************************
        // state register and registered memory request
        // **************************************************
        always_ff @(posedge clk) begin
                if (!rstN) begin
                        state    <= sFetch;
                        memValid <= 1'b0;
                        memWrite <= 1'b0;
                end else begin
                        state    <= nextState;
                        memValid <= (nextState == sFetch) || (nextState == sMemRead) ||
                                    (nextState == sMemWrite);
                        memWrite <= (nextState == sMemWrite);
                end
        end

        always_comb begin
                nextState = state;
                case (state)
                        sFetch:    if (memXfer) nextState = sDecode;
                        sDecode: begin
                                case (op)
                                        opR:              nextState = sExecR;
                                        opImm:            nextState = sExecI;
                                        opLoad, opStore:  nextState = sMemAddr;
                                        opBranch:         nextState = sBranch;
                                        opJal:            nextState = sJal;
                                        opJalr:           nextState = sJalr;
                                        opLui:            nextState = sExecLui;
                                        default:          nextState = sFetch;  // no-op.
                                endcase
                        end
                        sExecR, sExecI, sJal, sJalr: nextState = sAluWb;
                        sMemAddr:  nextState = (op == opLoad) ? sMemRead : sMemWrite;
                        sMemRead:  if (memXfer) nextState = sLoadWb;
                        sMemWrite: if (memXfer) nextState = sFetch;
                        default:   nextState = sFetch;
                endcase
        end

        // **************************************************
        // control outputs per state
        // **************************************************
        always_comb begin
                pcWrite   = 1'b0;
                adrSrc    = 1'b0;
                irWrite   = 1'b0;
                regWrite  = 1'b0;
                aluOp     = aluAdd;
                srcA      = srcAOldPc;
                srcB      = srcBImm;
                resultSrc = resAluOut;
                immFmt    = immI;
                case (state)
                        sFetch: begin
                                irWrite   = memValid;
                                pcWrite   = memXfer;   // pc + 4.
                                srcA      = srcAPc;
                                srcB      = srcBFour;
                                resultSrc = resAluNow;
                        end
                        sDecode: begin
                                // jump and branch targets go to the alu register.
                                if (op == opJalr)
                                        srcA = srcAReg;
                                if (op == opJal)
                                        immFmt = immJ;
                                else if (op != opJalr)
                                        immFmt = immB;
                        end
                        sExecR: begin
                                srcA  = srcAReg;
                                srcB  = srcBReg;
                                aluOp = aluFunct;
                        end
                        sExecI: begin
                                srcA = srcAReg;
                                // keep addi from reading imm[10] as sub.
                                aluOp = (func3 == 3'b000 && func7bit5) ? aluAdd : aluFunct;
                        end
                        sExecLui: begin
                                immFmt    = immU;
                                resultSrc = resImm;
                                regWrite  = 1'b1;
                        end
                        sBranch: begin
                                srcA    = srcAReg;
                                srcB    = srcBReg;
                                aluOp   = aluSub;
                                pcWrite = taken;
                        end
                        sJal, sJalr: begin
                                srcB    = srcBFour;   // link value into the alu register.
                                pcWrite = 1'b1;
                        end
                        sMemAddr: begin
                                srcA   = srcAReg;
                                immFmt = (op == opStore) ? immS : immI;
                        end
                        sMemRead, sMemWrite: adrSrc = 1'b1;
                        sLoadWb: begin
                                resultSrc = resMemData;
                                regWrite  = 1'b1;
                        end
                        sAluWb: regWrite = 1'b1;
                        default: ;
                endcase
        end

        // a stalled request, the DONE_ADDR store included, keeps its address and type.
        assert property (@(posedge clk) disable iff (!rstN)
                memValid && !memReady |=> memValid && $stable(adrSrc) && $stable(memWrite));

        assert property (@(posedge clk) disable iff (!rstN) !(regWrite && memWrite));

endmodule

`default_nettype wire

// ==== source/multiCycleCore.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvDefines.svh"

module multiCycleCore (
        input  wire                clk,
        input  wire                rstN,
        input  wire                memReady,
        input  wire [`XLEN-1:0]    memRdata,
        output logic               memValid,
        output logic               memWrite,
        output logic [`XLEN-1:0]   memAddr,
        output logic [`XLEN-1:0]   memWdata
);
        import rvPkg::*;

        opcode_t          op;
        aluOp_t           aluOp;
        srcA_t            srcA;
        srcB_t            srcB;
        resultSrc_t       resultSrc;
        immFmt_t          immFmt;
        logic             pcWrite, adrSrc, irWrite, regWrite;
        logic             zero, neg;
        logic [`XLEN-1:0] instr, imm, rd1, rd2, aluA, aluB, aluResult, result;

        assign op = opcode_t'(instr[6:0]);

        mainController ctrl (
                .clk(clk), .rstN(rstN), .op(op), .func3(instr[14:12]),
                .func7bit5(instr[30]), .zero(zero), .neg(neg), .memReady(memReady),
                .memValid(memValid), .memWrite(memWrite), .pcWrite(pcWrite),
                .adrSrc(adrSrc), .irWrite(irWrite), .regWrite(regWrite), .aluOp(aluOp),
                .srcA(srcA), .srcB(srcB), .resultSrc(resultSrc), .immFmt(immFmt)
        );

        stageRegisters stages (
                .clk(clk), .rstN(rstN), .pcWrite(pcWrite), .adrSrc(adrSrc),
                .irWrite(irWrite), .srcA(srcA), .srcB(srcB), .resultSrc(resultSrc),
                .memRdata(memRdata), .memReady(memReady), .rd1(rd1), .rd2(rd2),
                .imm(imm), .aluResult(aluResult), .instr(instr), .memAddr(memAddr),
                .memWdata(memWdata), .aluA(aluA), .aluB(aluB), .result(result)
        );

        registerFile regFile (
                .clk(clk), .rstN(rstN), .regWrite(regWrite), .ra1(instr[19:15]),
                .ra2(instr[24:20]), .wa(instr[11:7]), .wd(result), .rd1(rd1), .rd2(rd2)
        );

        alu alu0 (
                .aluOp(aluOp), .func3(instr[14:12]), .func7bit5(instr[30]), .a(aluA),
                .b(aluB), .y(aluResult), .zero(zero), .neg(neg)
        );

        immExtend immGen (
                .instr(instr[31:7]), .immFmt(immFmt), .imm(imm)
        );

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvDefines.svh"

module registerFile (
        input  wire                clk,
        input  wire                rstN,
        input  wire                regWrite,
        input  wire [4:0]          ra1,
        input  wire [4:0]          ra2,
        input  wire [4:0]          wa,
        input  wire [`XLEN-1:0]    wd,
        output logic [`XLEN-1:0]   rd1,
        output logic [`XLEN-1:0]   rd2
);
        logic [`XLEN-1:0] regs [`REG_COUNT];

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        for (int i = 0; i < `REG_COUNT; i++)
                                regs[i] <= '0;
                end else if (regWrite && wa != 5'd0) begin
                        regs[wa] <= wd;
                end
        end

        assign rd1 = regs[ra1];
        assign rd2 = regs[ra2];

        // x0 stays zero only because writes to it are dropped.
        assert property (@(posedge clk) disable iff (!rstN)
                (ra1 == 5'd0 -> rd1 == '0) && (ra2 == 5'd0 -> rd2 == '0));

endmodule

`default_nettype wire

// ==== source/rvDefines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width.
`define XLEN 32

// architectural registers, x0 included.
`define REG_COUNT 32

// first fetch address.
`define RESET_PC 32'h0000_0000

// programs store here when they finish.
`define DONE_ADDR 32'h0000_0ff0

`endif

// ==== source/rvPkg.sv ====
`default_nettype none

package rvPkg;

        typedef enum logic [3:0] {
                sFetch,
                sDecode,
                sExecR,
                sExecI,
                sExecLui,
                sBranch,
                sJal,
                sJalr,
                sMemAddr,
                sMemRead,
                sMemWrite,
                sLoadWb,
                sAluWb
        } ctrlState_t;

        // real RV32I major opcodes.
        typedef enum logic [6:0] {
                opR      = 7'b0110011,
                opImm    = 7'b0010011,
                opLoad   = 7'b0000011,
                opStore  = 7'b0100011,
                opBranch = 7'b1100011,
                opJal    = 7'b1101111,
                opJalr   = 7'b1100111,
                opLui    = 7'b0110111
        } opcode_t;

        typedef enum logic [1:0] {
                aluAdd,
                aluSub,   // also the compare for branches.
                aluFunct
        } aluOp_t;

        typedef enum logic [1:0] {
                resAluOut,
                resMemData,
                resAluNow,
                resImm
        } resultSrc_t;

        typedef enum logic [1:0] {srcAPc, srcAOldPc, srcAReg} srcA_t;

        typedef enum logic [1:0] {srcBReg, srcBImm, srcBFour} srcB_t;

        typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immFmt_t;

endpackage

`default_nettype wire

// ==== source/stageRegisters.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvDefines.svh"

module stageRegisters (
        input  wire                    clk,
        input  wire                    rstN,
        input  wire                    pcWrite,
        input  wire                    adrSrc,
        input  wire                    irWrite,
        input  rvPkg::srcA_t           srcA,
        input  rvPkg::srcB_t           srcB,
        input  rvPkg::resultSrc_t      resultSrc,
        input  wire [`XLEN-1:0]        memRdata,
        input  wire                    memReady,
        input  wire [`XLEN-1:0]        rd1,
        input  wire [`XLEN-1:0]        rd2,
        input  wire [`XLEN-1:0]        imm,
        input  wire [`XLEN-1:0]        aluResult,
        output logic [`XLEN-1:0]       instr,
        output logic [`XLEN-1:0]       memAddr,
        output logic [`XLEN-1:0]       memWdata,
        output logic [`XLEN-1:0]       aluA,
        output logic [`XLEN-1:0]       aluB,
        output logic [`XLEN-1:0]       result
);
        import rvPkg::*;

        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] oldPc;
        logic [`XLEN-1:0] memData;
        logic [`XLEN-1:0] aluOut;

        always_ff @(posedge clk) begin
                if (!rstN)
                        pc <= `RESET_PC;
                else if (pcWrite)
                        pc <= result;
        end

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        instr <= '0;
                end else if (irWrite && memReady) begin
                        instr <= memRdata;
                        oldPc <= pc;     // address of the fetched instruction.
                end
                if (memReady)
                        memData <= memRdata;
                if (!adrSrc)
                        aluOut <= aluResult;   // held while it addresses memory.
        end

        assign memAddr  = adrSrc ? aluOut : pc;
        assign memWdata = rd2;

        always_comb begin
                case (srcA)
                        srcAPc:    aluA = pc;
                        srcAOldPc: aluA = oldPc;
                        default:   aluA = rd1;
                endcase
                case (srcB)
                        srcBReg:  aluB = rd2;
                        srcBImm:  aluB = imm;
                        default:  aluB = `XLEN'd4;
                endcase
                case (resultSrc)
                        resAluOut:  result = aluOut;
                        resMemData: result = memData;
                        resAluNow:  result = aluResult;
                        default:    result = imm;
                endcase
        end

endmodule

`default_nettype wire

// ==== tests/coreTb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rvDefines.svh"

module coreTb;
        localparam int memWords = 1024;

        logic             clk;
        logic             rstN;
        logic             memReady;
        logic [`XLEN-1:0] memRdata;
        logic             memValid;
        logic             memWrite;
        logic [`XLEN-1:0] memAddr;
        logic [`XLEN-1:0] memWdata;

        logic [31:0] mem [memWords];
        logic [31:0] snapshot [memWords];
        logic [31:0] lfsr;
        logic        randomWaits;
        logic        doneSeen;
        logic        pending;
        int          waitLeft;
        int          emitIdx;
        logic        prevStall;
        logic [31:0] prevAddr;
        logic        prevWrite;

        multiCycleCore UUT (
                .clk(clk), .rstN(rstN), .memReady(memReady), .memRdata(memRdata),
                .memValid(memValid), .memWrite(memWrite), .memAddr(memAddr),
                .memWdata(memWdata)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        task automatic checkValue(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
                if (got !== expected) begin
                        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got,
                                 expected);
                        $display("=== FAIL ===");
                        $fatal(1, "value check failed");
                end
        endtask

        task automatic checkWord(input logic [31:0] addr, input logic [31:0] expected);
                checkValue($sformatf("mem[%h]", addr), mem[addr[11:2]], expected);
        endtask

        function automatic logic takeBit();
                logic b;
                b = lfsr[0];
                lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);   // galois step.
                return b;
        endfunction

        function automatic int pickWait();
                logic hi;
                logic lo;
                if (!randomWaits)
                        return 0;
                hi = takeBit();
                lo = takeBit();
                return {hi, lo};
        endfunction

        // **************************************************
        // memory model and handshake monitor
        // **************************************************
        always @(posedge clk) begin
                if (!rstN) begin
                        memReady <= 1'b0;
                        doneSeen <= 1'b0;
                        pending = 1'b0;
                end else if (memValid && memReady) begin
                        if (memWrite) begin
                                mem[memAddr[11:2]] = memWdata;
                                if (memAddr == `DONE_ADDR)
                                        doneSeen <= 1'b1;
                        end
                        memReady <= 1'b0;
                        pending = 1'b0;
                end else if (memValid) begin
                        if (!pending) begin
                                waitLeft = pickWait();   // new request.
                                pending = 1'b1;
                        end
                        if (waitLeft == 0) begin
                                memReady <= 1'b1;
                                memRdata <= mem[memAddr[11:2]];
                        end else begin
                                waitLeft = waitLeft - 1;
                        end
                end
        end

        always @(posedge clk) begin
                if (!rstN) begin
                        prevStall = 1'b0;
                end else begin
                        if (prevStall) begin   // stalled request must hold.
                                checkValue("memValid", memValid, 1);
                                checkValue("memAddr", memAddr, prevAddr);
                                checkValue("memWrite", memWrite, prevWrite);
                        end
                        prevStall = memValid && !memReady;
                        prevAddr  = memAddr;
                        prevWrite = memWrite;
                end
        end

        // **************************************************
        // instruction encoding and program loading
        // **************************************************
        function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [4:0] rs2,
                        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
        endfunction

        function automatic logic [31:0] encodeI(input int imm, input logic [4:0] rs1,
                        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
                return {imm[11:0], rs1, f3, rd, op};
        endfunction

        function automatic logic [31:0] addiInstr(input logic [4:0] rd, input logic [4:0] rs1,
                                                  input int imm);
                return encodeI(imm, rs1, 3'b000, rd, 7'b0010011);
        endfunction

        function automatic logic [31:0] swInstr(input logic [4:0] rs2, input logic [4:0] rs1,
                                                input int off);
                return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
        endfunction

        function automatic logic [31:0] encodeB(input int off, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
        endfunction

        function automatic logic [31:0] encodeJ(input int off, input logic [4:0] rd);
                return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
        endfunction

        task automatic emit(input logic [31:0] word);
                mem[emitIdx] = word;
                emitIdx++;
        endtask

        task automatic clearMemory();
                for (int i = 0; i < memWords; i++)
                        mem[i] = 32'hc0de_0000 | (i * 4);   // never a valid opcode.
                emitIdx = 0;
        endtask

        // 2040 + 2040 lands on DONE_ADDR and the jal spins in place.
        task automatic emitDone();
                emit(addiInstr(31, 0, 2040));
                emit(swInstr(0, 31, 2040));
                emit(encodeJ(0, 0));
        endtask

        task automatic enterReset();
                @(posedge clk);
                rstN <= 1'b0;
                @(posedge clk);
                @(negedge clk);
        endtask

        task automatic leaveReset();
                repeat (3) @(posedge clk);
                rstN <= 1'b1;
        endtask

        task automatic waitForDone(input int limit);
                int cycles;
                cycles = 0;
                while (!doneSeen) begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > limit) begin
                                $display("Timeout: no store to the done address in %0d cycles",
                                         limit);
                                $display("=== FAIL ===");
                                $fatal(1, "program did not finish");
                        end
                end
                @(negedge clk);
        endtask

        // **************************************************
        // directed tests
        // **************************************************
        task automatic testArithmetic();
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] expected [12];
                a = 100;
                b = -7;
                enterReset();
                clearMemory();
                emit(addiInstr(1, 0, 100));
                emit(addiInstr(2, 0, -7));
                emit(encodeR(7'b0000000, 2, 1, 3'b000, 3));   // add.
                emit(encodeR(7'b0100000, 1, 2, 3'b000, 4));   // sub x4 = x2 - x1.
                emit(encodeR(7'b0000000, 2, 1, 3'b111, 5));
                emit(encodeR(7'b0000000, 2, 1, 3'b110, 6));
                emit(encodeR(7'b0000000, 1, 2, 3'b010, 7));   // slt x2 < x1.
                emit(encodeR(7'b0000000, 2, 1, 3'b010, 8));
                emit(addiInstr(0, 1, 5));                      // x0 must ignore this.
                emit(encodeR(7'b0000000, 2, 0, 3'b000, 9));
                emit(encodeI(255, 2, 3'b111, 10, 7'b0010011));
                emit(encodeI(-256, 1, 3'b110, 11, 7'b0010011));
                for (int r = 0; r < 12; r++)
                        emit(swInstr(r, 0, 'h400 + 4 * r));
                emitDone();
                leaveReset();
                waitForDone(2000);
                expected[0]  = 0;
                expected[1]  = a;
                expected[2]  = b;
                expected[3]  = a + b;
                expected[4]  = b - a;
                expected[5]  = a & b;
                expected[6]  = a | b;
                expected[7]  = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
                expected[8]  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                expected[9]  = b;
                expected[10] = b & 32'h0000_00ff;
                expected[11] = a | 32'hffff_ff00;
                for (int r = 0; r < 12; r++)
                        checkWord('h400 + 4 * r, expected[r]);
        endtask

        task automatic testLoadStore();
                logic [31:0] p;
                logic [31:0] q;
                p = 32'h1234_5678;
                q = 32'hffff_fff0;
                enterReset();
                clearMemory();
                mem['h500 >> 2] = p;
                mem['h504 >> 2] = q;
                emit(encodeI('h500, 0, 3'b010, 1, 7'b0000011));
                emit(encodeI('h504, 0, 3'b010, 2, 7'b0000011));
                emit(addiInstr(3, 1, 1));
                emit(encodeR(7'b0000000, 2, 1, 3'b000, 4));
                emit(addiInstr(5, 0, 'h600));
                emit(swInstr(3, 5, 0));
                emit(swInstr(4, 5, 8));
                emit(swInstr(2, 5, -4));
                emitDone();
                leaveReset();
                waitForDone(2000);
                checkWord('h600, p + 1);
                checkWord('h608, p + q);
                checkWord('h5fc, q);
                checkWord('h604, 32'hc0de_0604);   // untouched between the stores.
                checkWord('h500, p);
        endtask

        task automatic loadBranchProgram();
                clearMemory();
                emit(addiInstr(1, 0, 0));
                emit(addiInstr(2, 0, 5));
                emit(addiInstr(1, 1, 1));
                emit(encodeB(-4, 2, 1, 3'b001));   // bne back.
                emit(addiInstr(3, 0, -2));
                emit(addiInstr(4, 0, 3));
                emit(addiInstr(3, 3, 1));
                emit(encodeB(-4, 4, 3, 3'b100));   // blt back.
                emit(addiInstr(5, 0, -1));
                emit(encodeB(8, 2, 1, 3'b000));    // beq taken.
                emit(swInstr(2, 0, 'h700));
                emit(encodeB(8, 5, 3, 3'b101));    // signed bge taken.
                emit(swInstr(2, 0, 'h704));
                emit(encodeB(8, 3, 5, 3'b101));    // bge not taken.
                emit(swInstr(4, 0, 'h708));
                emit(encodeB(8, 4, 1, 3'b000));    // beq not taken.
                emit(swInstr(1, 0, 'h70c));
                emit(swInstr(1, 0, 'h710));
                emit(swInstr(3, 0, 'h714));
                emitDone();
        endtask

        task automatic testBranches();
                int count;
                int signedCount;
                count = 0;
                do count++; while (count != 5);
                signedCount = -2;
                do signedCount++; while (signedCount < 3);
                enterReset();
                loadBranchProgram();
                leaveReset();
                waitForDone(2000);
                checkWord('h700, 32'hc0de_0700);
                checkWord('h704, 32'hc0de_0704);
                checkWord('h708, 3);
                checkWord('h70c, count);
                checkWord('h710, count);
                checkWord('h714, signedCount);
                for (int i = 0; i < memWords; i++)
                        snapshot[i] = mem[i];
        endtask

        task automatic testJumps();
                logic [31:0] jalAddr;
                logic [31:0] jalrAddr;
                enterReset();
                clearMemory();
                jalAddr = emitIdx * 4;
                emit(encodeJ(12, 1));
                emit(addiInstr(9, 0, 99));
                emit(swInstr(9, 0, 'h72c));
                emit(swInstr(1, 0, 'h720));
                emit(addiInstr(5, 0, 'h20));
                jalrAddr = emitIdx * 4;
                emit(encodeI(4, 5, 3'b000, 6, 7'b1100111));   // to 0x24.
                repeat (3) emit(swInstr(5, 0, 'h730));
                emit(swInstr(6, 0, 'h724));
                emit({20'habcde, 5'd7, 7'b0110111});          // lui x7.
                emit(swInstr(7, 0, 'h728));
                emitDone();
                leaveReset();
                waitForDone(2000);
                checkWord('h720, jalAddr + 4);
                checkWord('h724, jalrAddr + 4);
                checkWord('h728, {20'habcde, 12'h000});
                checkWord('h72c, 32'hc0de_072c);
                checkWord('h730, 32'hc0de_0730);
        endtask

        task automatic testBackPressure();
                randomWaits = 1'b1;
                enterReset();
                loadBranchProgram();
                leaveReset();
                waitForDone(8000);
                for (int i = 0; i < memWords; i++)
                        checkValue($sformatf("mem[%h]", i * 4), mem[i], snapshot[i]);
        endtask

        task automatic testReset();
                int cycles;
                @(posedge clk);
                rstN <= 1'b0;
                repeat (3) begin
                        @(posedge clk);
                        @(negedge clk);
                        checkValue("memValid", memValid, 0);
                end
                @(posedge clk);
                rstN <= 1'b1;
                @(negedge clk);
                checkValue("memValid", memValid, 0);
                cycles = 0;
                while (!memValid) begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > 10) begin
                                $display("Timeout: no memory request after reset");
                                $display("=== FAIL ===");
                                $fatal(1, "no first fetch");
                        end
                end
                checkValue("memAddr", memAddr, `RESET_PC);
                checkValue("memWrite", memWrite, 0);
                waitForDone(8000);
        endtask

        initial begin
                rstN        <= 1'b0;
                memReady    <= 1'b0;
                memRdata    <= '0;
                randomWaits = 1'b0;
                lfsr        = 32'h545d_ed18;
                emitIdx     = 0;
                testArithmetic();
                testLoadStore();
                testBranches();
                testJumps();
                testBackPressure();
                testReset();
                $display("=== PASS ===");
                $finish;
        end

endmodule

`default_nettype wire
